// ==== Makefile ====
# Verilator build and run of the LSU subsystem testbench

sim:
	verilator --binary --timing --assert --top-module lsu_subsys_tb -f flist.f \
		--Mdir obj_dir -o lsu_sim
	./obj_dir/lsu_sim | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== flist.f ====
+incdir+tests
hw/lsu_pkg.sv
hw/lsu_req_skid.sv
hw/lsu_core.sv
hw/lsu_scratchpad.sv
hw/lsu_subsys.sv
tests/lsu_subsys_tb.sv

// ==== hw/lsu_core.sv ====
/*
 * LSU core, tracks outstanding memory IDs, aligns stores and extends loads
 * Memory responses may return in any order
 */

`default_nettype none

module lsu_core #(
  parameter int unsigned NumOutstanding = 4
) (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire lsu_pkg::lsu_req_t req_i,
  input  wire logic              req_valid_i,
  output      logic              req_ready_o,
  output      lsu_pkg::mem_req_t mem_req_o,
  output      logic              mem_req_valid_o,
  input  wire logic              mem_req_ready_i,
  input  wire lsu_pkg::mem_rsp_t mem_rsp_i,
  input  wire logic              mem_rsp_valid_i,
  output      logic              mem_rsp_ready_o,
  output      lsu_pkg::lsu_rsp_t rsp_o,
  output      logic              rsp_valid_o,
  input  wire logic              rsp_ready_i,
  output      logic              empty_o
);

  typedef struct packed {
    logic          write;
    lsu_pkg::tag_t tag;
    logic          sign_ext;
    logic [1:0]    offset;
    logic [1:0]    size;
  } meta_t;

  if (NumOutstanding < 1 || NumOutstanding > 4) begin : g_bad_outstanding
    $error("NumOutstanding must be 1 to 4");
  end

  logic [NumOutstanding-1:0] id_available_d, id_available_q;
  meta_t [NumOutstanding-1:0] meta_d, meta_q;
  meta_t                      req_meta, rsp_meta;
  lsu_pkg::mem_id_t           free_id, req_id_q, rsp_id;
  logic                       pending_q;
  logic                       id_table_full;
  logic                       id_push, id_pop;
  logic [31:0]                shifted_data;
  logic [31:0]                ld_result;

  // --------------------------------------------------
  // ID table
  // --------------------------------------------------
  // Lowest free ID wins
  always_comb begin
    free_id = '0;
    for (int i = NumOutstanding - 1; i >= 0; i--) begin
      if (id_available_q[i]) begin
        free_id = lsu_pkg::mem_id_t'(i);
      end
    end
  end

  assign id_table_full = ~|id_available_q;
  assign empty_o       = &id_available_q;

  assign req_meta = '{
    write:    req_i.write,
    tag:      req_i.tag,
    sign_ext: req_i.is_signed,
    offset:   req_i.addr[1:0],
    size:     req_i.size
  };

  // Claim on first raise of valid, not on the handshake
  assign id_push = mem_req_valid_o && !pending_q;
  assign id_pop  = mem_rsp_valid_i && mem_rsp_ready_o;
  assign rsp_id  = mem_rsp_i.id;

  always_comb begin
    id_available_d = id_available_q;
    meta_d         = meta_q;
    if (id_push) begin
      id_available_d[free_id] = 1'b0;
      meta_d[free_id]         = req_meta;
    end
    if (id_pop) begin
      id_available_d[rsp_id] = 1'b1;
    end
  end

  // --------------------------------------------------
  // Request side
  // --------------------------------------------------
  assign mem_req_valid_o = req_valid_i && (!id_table_full || pending_q);
  assign req_ready_o     = mem_req_ready_i && (!id_table_full || pending_q);

  assign mem_req_o.write = req_i.write;
  assign mem_req_o.id    = pending_q ? req_id_q : free_id;
  assign mem_req_o.addr  = {req_i.addr[31:2], 2'b00};

  always_comb begin
    unique case (req_i.size)
      2'b00:   mem_req_o.strb = 4'b0001 << req_i.addr[1:0];
      2'b01:   mem_req_o.strb = 4'b0011 << req_i.addr[1:0];
      2'b10:   mem_req_o.strb = 4'b1111;
      default: mem_req_o.strb = 4'b0000;
    endcase
  end

  // Rotate store data up to its byte lane
  always_comb begin
    unique case (req_i.addr[1:0])
      2'b01:   mem_req_o.wdata = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   mem_req_o.wdata = {req_i.wdata[15:0], req_i.wdata[31:16]};
      2'b11:   mem_req_o.wdata = {req_i.wdata[7:0], req_i.wdata[31:8]};
      default: mem_req_o.wdata = req_i.wdata;
    endcase
  end

  // --------------------------------------------------
  // Response side
  // --------------------------------------------------
  assign rsp_meta     = meta_q[rsp_id];
  assign shifted_data = mem_rsp_i.rdata >> {rsp_meta.offset, 3'b000};

  always_comb begin
    unique case (rsp_meta.size)
      2'b00:   ld_result = {{24{shifted_data[7] & rsp_meta.sign_ext}}, shifted_data[7:0]};
      2'b01:   ld_result = {{16{shifted_data[15] & rsp_meta.sign_ext}}, shifted_data[15:0]};
      default: ld_result = shifted_data;
    endcase
  end

  // Write acks are absorbed here
  assign rsp_valid_o     = mem_rsp_valid_i && !rsp_meta.write;
  assign mem_rsp_ready_o = rsp_ready_i || rsp_meta.write;
  assign rsp_o.tag       = rsp_meta.tag;
  assign rsp_o.rdata     = ld_result;
  assign rsp_o.error     = mem_rsp_i.error;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      id_available_q <= '1;
      meta_q         <= '0;
      req_id_q       <= '0;
      pending_q      <= 1'b0;
    end else begin
      id_available_q <= id_available_d;
      meta_q         <= meta_d;
      pending_q      <= mem_req_valid_o && !mem_req_ready_i;
      if (id_push && !mem_req_ready_i) begin
        req_id_q <= free_id;
      end
    end
  end

  claimed_id_free : assert property (
    @(posedge clk_i) disable iff (rst_i)
    id_push |-> id_available_q[free_id])
    else $error("claimed ID was not free");

  // Memory must only answer IDs it was handed
  rsp_id_in_use : assert property (
    @(posedge clk_i) disable iff (rst_i)
    id_pop |-> !id_available_q[rsp_id])
    else $error("response ID not in use");

endmodule

`default_nettype wire

// ==== hw/lsu_pkg.sv ====
/*
 * LSU shared types for the request, memory and response channels
 */

`default_nettype none

package lsu_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned TagWidth = 5;
  localparam int unsigned IdWidth  = 2;

  typedef logic [TagWidth-1:0] tag_t;
  typedef logic [IdWidth-1:0]  mem_id_t;

  // --------------------------------------------------
  // Channel payloads
  // --------------------------------------------------
  // Core request, size 0 byte, 1 half, 2 word
  typedef struct packed {
    logic        write;
    logic        is_signed;
    logic [1:0]  size;
    tag_t        tag;
    logic [31:0] addr;
    logic [31:0] wdata;
  } lsu_req_t;

  // Word aligned memory access with lane aligned data
  typedef struct packed {
    logic        write;
    mem_id_t     id;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
  } mem_req_t;

  typedef struct packed {
    mem_id_t     id;
    logic [31:0] rdata;
    logic        error;
  } mem_rsp_t;

  // Load result back to the core
  typedef struct packed {
    tag_t        tag;
    logic [31:0] rdata;
    logic        error;
  } lsu_rsp_t;

endpackage

`default_nettype wire

// ==== hw/lsu_req_skid.sv ====
/*
 * Request skid buffer, two entries, registered ready at full throughput
 */

`default_nettype none

module lsu_req_skid (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire lsu_pkg::lsu_req_t req_i,
  input  wire logic              req_valid_i,
  output      logic              req_ready_o,
  output      lsu_pkg::lsu_req_t req_o,
  output      logic              req_valid_o,
  input  wire logic              req_ready_i
);

  lsu_pkg::lsu_req_t main_q, spare_q;
  logic              main_valid_q, spare_valid_q;
  logic              accept_in;
  logic              load_main;

  assign accept_in = req_valid_i && req_ready_o;
  // Main register frees up when empty or when its entry leaves
  assign load_main = !main_valid_q || req_ready_i;

  // Only the spare entry blocks new requests
  assign req_ready_o = !spare_valid_q;
  assign req_valid_o = main_valid_q;
  assign req_o       = main_q;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      main_valid_q  <= 1'b0;
      spare_valid_q <= 1'b0;
    end else if (load_main) begin
      main_valid_q  <= spare_valid_q || accept_in;
      spare_valid_q <= 1'b0;
    end else if (accept_in) begin
      spare_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_main) begin
      if (spare_valid_q) begin
        main_q <= spare_q;
      end else if (accept_in) begin
        main_q <= req_i;
      end
    end else if (accept_in) begin
      spare_q <= req_i;
    end
  end

  // Downstream sees a stable request until it takes it
  stable_while_stalled : assert property (
    @(posedge clk_i) disable iff (rst_i)
    (req_valid_o && !req_ready_i) |=> (req_valid_o && $stable(req_o)))
    else $error("skid output changed while stalled");

endmodule

`default_nettype wire

// ==== hw/lsu_scratchpad.sv ====
/*
 * Scratchpad model, byte strobed words with a fast and a slow return lane
 * so responses come back out of order
 */

`default_nettype none

module lsu_scratchpad #(
  parameter int unsigned MemWords = 64
) (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire lsu_pkg::mem_req_t req_i,
  input  wire logic              req_valid_i,
  output      logic              req_ready_o,
  output      lsu_pkg::mem_rsp_t rsp_o,
  output      logic              rsp_valid_o,
  input  wire logic              rsp_ready_i
);

  localparam int unsigned AddrBits = (MemWords > 1) ? $clog2(MemWords) : 1;

  logic [31:0]         mem_q [MemWords];
  logic [AddrBits-1:0] word_idx;
  logic                in_range;
  logic                slow_sel;
  logic                accept, accept_fast, accept_slow;
  lsu_pkg::mem_rsp_t   rsp_d;

  // Lane state
  lsu_pkg::mem_rsp_t fast_q, slow_q;
  logic              fast_valid_q, slow_busy_q, fast_hold_q;
  logic [1:0]        slow_cnt_q;
  logic              slow_ready, show_slow;
  logic              pop_fast, pop_slow;

  // --------------------------------------------------
  // Request decode
  // --------------------------------------------------
  assign word_idx = req_i.addr[AddrBits+1:2];
  assign in_range = {2'b00, req_i.addr[31:2]} < 32'(MemWords);
  assign slow_sel = req_i.addr[2];

  assign req_ready_o = slow_sel ? !slow_busy_q : !fast_valid_q;
  assign accept      = req_valid_i && req_ready_o;
  assign accept_fast = accept && !slow_sel;
  assign accept_slow = accept && slow_sel;

  // Read data is captured at acceptance
  assign rsp_d.id    = req_i.id;
  assign rsp_d.error = !in_range;
  assign rsp_d.rdata = (in_range && !req_i.write) ? mem_q[word_idx] : 32'h0;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      for (int i = 0; i < MemWords; i++) begin
        mem_q[i] <= '0;
      end
    end else if (accept && req_i.write && in_range) begin
      for (int b = 0; b < 4; b++) begin
        if (req_i.strb[b]) begin
          mem_q[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  // --------------------------------------------------
  // Return lanes
  // --------------------------------------------------
  assign slow_ready = slow_busy_q && (slow_cnt_q == 2'd0);
  // Slow first, unless a fast item is already on display
  assign show_slow  = slow_ready && !fast_hold_q;

  assign rsp_valid_o = slow_ready || fast_valid_q;
  assign rsp_o       = show_slow ? slow_q : fast_q;
  assign pop_slow    = show_slow && rsp_ready_i;
  assign pop_fast    = fast_valid_q && !show_slow && rsp_ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      fast_valid_q <= 1'b0;
      slow_busy_q  <= 1'b0;
      slow_cnt_q   <= 2'd0;
      fast_hold_q  <= 1'b0;
    end else begin
      fast_hold_q <= fast_valid_q && !show_slow && !rsp_ready_i;
      if (accept_fast) begin
        fast_valid_q <= 1'b1;
      end else if (pop_fast) begin
        fast_valid_q <= 1'b0;
      end
      if (accept_slow) begin
        slow_busy_q <= 1'b1;
        slow_cnt_q  <= 2'd2;
      end else if (pop_slow) begin
        slow_busy_q <= 1'b0;
      end else if (slow_busy_q && slow_cnt_q != 2'd0) begin
        slow_cnt_q <= slow_cnt_q - 2'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_fast) begin
      fast_q <= rsp_d;
    end
    if (accept_slow) begin
      slow_q <= rsp_d;
    end
  end

  // A held lane item survives until its own pop
  lane_not_overwritten : assert property (
    @(posedge clk_i) disable iff (rst_i)
    ((fast_valid_q && !pop_fast) |=> (fast_valid_q && $stable(fast_q))) and
    ((slow_busy_q && !pop_slow) |=> (slow_busy_q && $stable(slow_q))))
    else $error("scratchpad lane overwritten");

endmodule

`default_nettype wire

// ==== hw/lsu_subsys.sv ====
/*
 * LSU subsystem top, skid buffer into ID-tracking core into scratchpad
 */

`default_nettype none

module lsu_subsys #(
  parameter int unsigned NumOutstanding = 4,
  parameter int unsigned MemWords       = 64
) (
  input  wire logic              clk_i,
  input  wire logic              rst_i,
  input  wire lsu_pkg::lsu_req_t req_i,
  input  wire logic              req_valid_i,
  output      logic              req_ready_o,
  output      lsu_pkg::lsu_rsp_t rsp_o,
  output      logic              rsp_valid_o,
  input  wire logic              rsp_ready_i,
  output      logic              empty_o
);

  // Skid buffer to LSU core
  lsu_pkg::lsu_req_t skid_req;
  logic              skid_valid, skid_ready;

  // LSU core to and from the scratchpad
  lsu_pkg::mem_req_t mem_req;
  logic              mem_req_valid, mem_req_ready;
  lsu_pkg::mem_rsp_t mem_rsp;
  logic              mem_rsp_valid, mem_rsp_ready;

  lsu_req_skid u_lsu_req_skid (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_o       (skid_req),
    .req_valid_o (skid_valid),
    .req_ready_i (skid_ready)
  );

  lsu_core #(
    .NumOutstanding (NumOutstanding)
  ) u_lsu_core (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .req_i           (skid_req),
    .req_valid_i     (skid_valid),
    .req_ready_o     (skid_ready),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_rsp_i       (mem_rsp),
    .mem_rsp_valid_i (mem_rsp_valid),
    .mem_rsp_ready_o (mem_rsp_ready),
    .rsp_o           (rsp_o),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .empty_o         (empty_o)
  );

  lsu_scratchpad #(
    .MemWords (MemWords)
  ) u_lsu_scratchpad (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (mem_req),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .rsp_o       (mem_rsp),
    .rsp_valid_o (mem_rsp_valid),
    .rsp_ready_i (mem_rsp_ready)
  );

endmodule

`default_nettype wire

// ==== tests/lsu_tb_table.svh ====
/*
 * LSU testbench stimulus table, one access per entry, tag is the entry index
 */

`ifndef LSU_TB_TABLE_SVH
`define LSU_TB_TABLE_SVH

localparam int NumEntries = 32;

typedef struct packed {
  logic        write;
  logic        is_signed;
  logic [1:0]  size;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] exp_data;
  logic        exp_err;
} entry_t;

entry_t table_q [NumEntries];

function automatic entry_t make_entry(
  input logic        write,
  input logic        is_signed,
  input logic [1:0]  size,
  input logic [31:0] addr,
  input logic [31:0] wdata,
  input logic [31:0] exp_data,
  input logic        exp_err
);
  return '{write, is_signed, size, addr, wdata, exp_data, exp_err};
endfunction

// Field order is write, signed, size, addr, wdata, expected data, expected error
task automatic fill_table();
  // Byte stores into fast-lane word 0x10, upper wdata bits must be masked
  table_q[0]  = make_entry(1'b1, 1'b0, 2'd0, 32'h0010, 32'hffffff44, 32'h00000000, 1'b0);
  table_q[1]  = make_entry(1'b1, 1'b0, 2'd0, 32'h0011, 32'h123456a3, 32'h00000000, 1'b0);
  table_q[2]  = make_entry(1'b1, 1'b0, 2'd0, 32'h0012, 32'h0000005c, 32'h00000000, 1'b0);
  table_q[3]  = make_entry(1'b1, 1'b0, 2'd0, 32'h0013, 32'habcdef91, 32'h00000000, 1'b0);
  // Word 0x10 now holds 0x915ca344
  table_q[4]  = make_entry(1'b0, 1'b0, 2'd2, 32'h0010, 32'h00000000, 32'h915ca344, 1'b0);
  table_q[5]  = make_entry(1'b0, 1'b1, 2'd0, 32'h0010, 32'h00000000, 32'h00000044, 1'b0);
  table_q[6]  = make_entry(1'b0, 1'b1, 2'd0, 32'h0011, 32'h00000000, 32'hffffffa3, 1'b0);
  table_q[7]  = make_entry(1'b0, 1'b0, 2'd0, 32'h0011, 32'h00000000, 32'h000000a3, 1'b0);
  table_q[8]  = make_entry(1'b0, 1'b1, 2'd0, 32'h0013, 32'h00000000, 32'hffffff91, 1'b0);
  table_q[9]  = make_entry(1'b0, 1'b0, 2'd0, 32'h0012, 32'h00000000, 32'h0000005c, 1'b0);
  table_q[10] = make_entry(1'b0, 1'b1, 2'd1, 32'h0012, 32'h00000000, 32'hffff915c, 1'b0);
  table_q[11] = make_entry(1'b0, 1'b0, 2'd1, 32'h0012, 32'h00000000, 32'h0000915c, 1'b0);
  table_q[12] = make_entry(1'b0, 1'b1, 2'd1, 32'h0010, 32'h00000000, 32'hffffa344, 1'b0);
  // Word, half and byte stores merged into slow-lane word 0x14
  table_q[13] = make_entry(1'b1, 1'b0, 2'd2, 32'h0014, 32'h12345678, 32'h00000000, 1'b0);
  table_q[14] = make_entry(1'b1, 1'b0, 2'd1, 32'h0016, 32'hffffbeef, 32'h00000000, 1'b0);
  table_q[15] = make_entry(1'b1, 1'b0, 2'd1, 32'h0014, 32'h00008001, 32'h00000000, 1'b0);
  table_q[16] = make_entry(1'b1, 1'b0, 2'd0, 32'h0017, 32'h00000022, 32'h00000000, 1'b0);
  // Word 0x14 now holds 0x22ef8001
  table_q[17] = make_entry(1'b0, 1'b0, 2'd2, 32'h0014, 32'h00000000, 32'h22ef8001, 1'b0);
  table_q[18] = make_entry(1'b0, 1'b1, 2'd1, 32'h0014, 32'h00000000, 32'hffff8001, 1'b0);
  table_q[19] = make_entry(1'b0, 1'b0, 2'd1, 32'h0016, 32'h00000000, 32'h000022ef, 1'b0);
  table_q[20] = make_entry(1'b0, 1'b1, 2'd0, 32'h0016, 32'h00000000, 32'hffffffef, 1'b0);
  table_q[21] = make_entry(1'b0, 1'b0, 2'd0, 32'h0015, 32'h00000000, 32'h00000080, 1'b0);
  // Fast and slow lanes interleaved
  table_q[22] = make_entry(1'b0, 1'b0, 2'd2, 32'h0008, 32'h00000000, 32'h00000000, 1'b0);
  table_q[23] = make_entry(1'b0, 1'b0, 2'd2, 32'h000c, 32'h00000000, 32'h00000000, 1'b0);
  table_q[24] = make_entry(1'b0, 1'b0, 2'd1, 32'h0010, 32'h00000000, 32'h0000a344, 1'b0);
  // Beyond the 64 words, and word 0 must not see the aliased store
  table_q[25] = make_entry(1'b0, 1'b0, 2'd2, 32'h0400, 32'h00000000, 32'h00000000, 1'b1);
  table_q[26] = make_entry(1'b1, 1'b0, 2'd2, 32'h0400, 32'hdeadbeef, 32'h00000000, 1'b0);
  table_q[27] = make_entry(1'b0, 1'b0, 2'd2, 32'h0400, 32'h00000000, 32'h00000000, 1'b1);
  table_q[28] = make_entry(1'b0, 1'b1, 2'd0, 32'h0103, 32'h00000000, 32'h00000000, 1'b1);
  table_q[29] = make_entry(1'b0, 1'b0, 2'd2, 32'h0000, 32'h00000000, 32'h00000000, 1'b0);
  table_q[30] = make_entry(1'b0, 1'b0, 2'd2, 32'h0014, 32'h00000000, 32'h22ef8001, 1'b0);
  table_q[31] = make_entry(1'b0, 1'b0, 2'd0, 32'h0013, 32'h00000000, 32'h00000091, 1'b0);
endtask

`endif

// ==== tests/lsu_subsys_tb.sv ====
/*
 * LSU subsystem testbench, table driven accesses with random response back-pressure
 */

`default_nettype none

module lsu_subsys_tb;

  localparam int Period = 40;

  `include "lsu_tb_table.svh"

  logic                  clk_i;
  logic                  rst_i;
  lsu_pkg::lsu_req_t     req_i;
  logic                  req_valid_i;
  logic                  req_ready_o;
  lsu_pkg::lsu_rsp_t     rsp_o;
  logic                  rsp_valid_o;
  logic                  rsp_ready_i;
  logic                  empty_o;

  integer                seed;
  logic [NumEntries-1:0] seen_q;
  int                    loads_seen;
  int                    loads_total;
  int                    next_idx;

  lsu_subsys #(
    .NumOutstanding (4),
    .MemWords       (64)
  ) u_lsu_subsys (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .rsp_o       (rsp_o),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .empty_o     (empty_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(Period / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
    abort_run();
  endtask

  function automatic int count_loads();
    int n;
    n = 0;
    for (int i = 0; i < NumEntries; i++) begin
      if (!table_q[i].write) begin
        n++;
      end
    end
    return n;
  endfunction

  function automatic lsu_pkg::lsu_req_t to_request(input int idx);
    lsu_pkg::lsu_req_t req;
    req.write     = table_q[idx].write;
    req.is_signed = table_q[idx].is_signed;
    req.size      = table_q[idx].size;
    req.tag       = lsu_pkg::tag_t'(idx);
    req.addr      = table_q[idx].addr;
    req.wdata     = table_q[idx].wdata;
    return req;
  endfunction

  // Look up the entry named by the tag
  task automatic check_response(input lsu_pkg::lsu_rsp_t rsp);
    int t;
    t = int'(rsp.tag);
    assert (t < NumEntries && !table_q[t].write) else begin
      $display("response at %0t carries tag %0d which names no load", $time, t);
      abort_run();
    end
    assert (!seen_q[t]) else begin
      $display("tag %0d answered a second time at %0t", t, $time);
      abort_run();
    end
    seen_q[t] = 1'b1;
    loads_seen++;
    assert (rsp.rdata == table_q[t].exp_data) else begin
      report_mismatch($sformatf("rsp_o.rdata tag %0d", t), rsp.rdata, table_q[t].exp_data);
    end
    assert (rsp.error == table_q[t].exp_err) else begin
      report_mismatch($sformatf("rsp_o.error tag %0d", t), 32'(rsp.error),
                      32'(table_q[t].exp_err));
    end
  endtask

  // --------------------------------------------------
  // Stimulus and checking
  // --------------------------------------------------
  initial begin
    rst_i       = 1'b1;
    req_i       = '0;
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b0;
    seed        = 32'haa8f4891;
    seen_q      = '0;
    loads_seen  = 0;
    next_idx    = 0;
    fill_table();
    loads_total = count_loads();

    repeat (8) @(negedge clk_i);
    rst_i = 1'b0;
    #1;
    assert (req_ready_o === 1'b1) else report_mismatch("req_ready_o", 32'(req_ready_o), 32'd1);
    assert (rsp_valid_o === 1'b0) else report_mismatch("rsp_valid_o", 32'(rsp_valid_o), 32'd0);
    assert (empty_o === 1'b1) else report_mismatch("empty_o", 32'(empty_o), 32'd1);

    // Inputs change on the falling edge, handshakes are sampled just after
    while (next_idx < NumEntries || loads_seen < loads_total) begin
      @(negedge clk_i);
      if (next_idx < NumEntries) begin
        req_valid_i = 1'b1;
        req_i       = to_request(next_idx);
      end else begin
        req_valid_i = 1'b0;
      end
      rsp_ready_i = (($random(seed) & 3) != 0);
      #1;
      if (rsp_valid_o) begin
        // A pending load response still holds its ID
        assert (!empty_o) else report_mismatch("empty_o", 32'(empty_o), 32'd0);
      end
      if (rsp_valid_o && rsp_ready_i) begin
        check_response(rsp_o);
      end
      if (req_valid_i && req_ready_o) begin
        next_idx++;
      end
    end

    @(negedge clk_i);
    req_valid_i = 1'b0;
    rsp_ready_i = 1'b1;
    while (!empty_o) begin
      @(negedge clk_i);
    end

    // Nothing more may come back once all IDs are free
    repeat (10) begin
      @(negedge clk_i);
      #1;
      assert (!rsp_valid_o) else begin
        $display("unexpected extra response at %0t with tag %0d", $time, rsp_o.tag);
        abort_run();
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    repeat (NumEntries * 20 + 100) @(posedge clk_i);
    $display("timeout after %0d cycles, the run did not finish", NumEntries * 20 + 100);
    abort_run();
  end

endmodule

`default_nettype wire
